//--- gfx_cfg_pkg.sv
// Video mixer configuration definitions
// CPU register map, bit positions inside the kept registers and the
// horizontal limits of the layer windows and the screen border
`default_nettype none

package gfx_cfg_pkg;

    typedef logic [2:0] cfg_addr_t;
    typedef logic [7:0] cfg_data_t;
    typedef logic [1:0] pal_bank_t;

    // Kept register addresses
    localparam cfg_addr_t REG_MODE = 3'd3;
    localparam cfg_addr_t REG_PRIO = 3'd6;
    localparam cfg_addr_t REG_CTRL = 3'd7;

    // REG_MODE bits
    localparam int BIT_LAYOUT = 4;   // 1 selects the wide layout
    localparam int BIT_NARROW = 6;

    // REG_PRIO bits, palette bank in 5:4
    localparam int BIT_SCRWIN = 3;
    localparam int BIT_PAL_LO = 4;

    // REG_CTRL bits
    localparam int BIT_FLIP = 3;

    // Narrow layout, both tile layers share one window
    localparam logic [8:0] NARROW_START = 9'd16;
    localparam logic [8:0] NARROW_END   = 9'd264;

    // Wide layout windows
    localparam logic [8:0] WIDE_CHR_END    = 9'd40;
    localparam logic [8:0] WIDE_SCR_END    = 9'd296;
    localparam logic [8:0] WIDE_FLIP_SPLIT = 9'd240;

    // Border blanking limits
    localparam logic [8:0] BORDER_NARROW_LO = 9'd24;
    localparam logic [8:0] BORDER_NARROW_HI = 9'd264;
    localparam logic [8:0] BORDER_WIDE_LO   = 9'd16;
    localparam logic [8:0] BORDER_WIDE_HI   = 9'd272;

    localparam logic [8:0] VBLANK_TOP = 9'd16;

endpackage

`default_nettype wire

//--- gfx_pix_pkg.sv
// Pixel definitions for the line buffers
// Payload types, layer codes and line geometry
`default_nettype none

package gfx_pix_pkg;

    typedef logic [8:0] pos_t;

    // Bit 8 marks the scroll window, low nibble zero is transparent
    typedef logic [8:0] tile_pxl_t;
    typedef logic [7:0] obj_pxl_t;

    typedef logic [1:0] layer_t;
    localparam layer_t LYR_CHR = 2'd0;
    localparam layer_t LYR_SCR = 2'd1;
    localparam layer_t LYR_OBJ = 2'd2;

    // Widest of the layer payloads
    typedef logic [8:0] wr_data_t;

    typedef logic [6:0] pal_idx_t;

    localparam int LINE_DEPTH = 512;

endpackage

`default_nettype wire

//--- gfx_cfg_regs.sv
// Configuration register file
// Captures CPU writes to the mode, priority and control registers and
// presents the decoded layout, border, flip, window and palette bits
`timescale 1ns/1ps
`default_nettype none

module gfx_cfg_regs
    import gfx_cfg_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            cfg_we,
    input  wire cfg_addr_t cfg_addr,
    input  wire cfg_data_t cfg_din,
    output logic           layout,
    output logic           narrow_en,
    output logic           flip,
    output logic           scrwin_en,
    output pal_bank_t      pal_bank
);

    // Only the bits with a function are stored
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layout    <= 1'b0;
            narrow_en <= 1'b0;
            flip      <= 1'b0;
            scrwin_en <= 1'b0;
            pal_bank  <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_MODE: begin
                    layout    <= cfg_din[BIT_LAYOUT];
                    narrow_en <= cfg_din[BIT_NARROW];
                end
                REG_PRIO: begin
                    scrwin_en <= cfg_din[BIT_SCRWIN];
                    pal_bank  <= cfg_din[BIT_PAL_LO +: $bits(pal_bank_t)];
                end
                REG_CTRL: begin
                    flip <= cfg_din[BIT_FLIP];
                end
                default: begin
                    // Scroll, strip and IRQ registers are not kept
                end
            endcase
        end
    end

    // An unknown address on a write could corrupt any kept register
    a_cfg_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        cfg_we |-> !$isunknown(cfg_addr)
    );

endmodule

`default_nettype wire

//--- line_writer.sv
// Line writer
// Accepts renderer pixels over a four-phase req/ack port and writes each
// one into the write bank of the character, scroll or object line buffer
`timescale 1ns/1ps
`default_nettype none

module line_writer
    import gfx_pix_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           wr_req,
    input  wire layer_t   wr_layer,
    input  wire pos_t     wr_addr,
    input  wire wr_data_t wr_data,
    input  wire           line,
    output logic          wr_ack,
    output logic          chr_we,
    output logic          scr_we,
    output logic          obj_we,
    output logic [9:0]    buf_addr,
    output wr_data_t      buf_data
);

    typedef enum logic {ST_IDLE, ST_ACK} wr_state_t;

    wr_state_t state;
    logic      req_q;
    logic      accept;

    // Request is sampled first, the write follows one edge later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q <= 1'b0;
            state <= ST_IDLE;
        end else begin
            req_q <= wr_req;
            case (state)
                ST_IDLE: if (req_q) state <= ST_ACK;
                ST_ACK:  if (!req_q) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // One write per handshake, held off until the ack has dropped
    assign accept = req_q && (state == ST_IDLE);
    assign wr_ack = (state == ST_ACK);

    assign chr_we = accept && (wr_layer == LYR_CHR);
    assign scr_we = accept && (wr_layer == LYR_SCR);
    assign obj_we = accept && (wr_layer == LYR_OBJ);

    // Write bank is the line signal itself
    assign buf_addr = {line, wr_addr};
    assign buf_data = wr_data;

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(wr_ack) |-> $past(wr_req)
    );

    a_layer_valid: assert property (
        @(posedge clk) disable iff (rst)
        wr_req |-> (wr_layer != 2'd3)
    );

endmodule

`default_nettype wire

//--- line_buffer.sv
// Ping-pong line buffer
// Two banks of one scan line each, one write port and one registered
// read port, the bank being the top address bit
`timescale 1ns/1ps
`default_nettype none

module line_buffer
    import gfx_pix_pkg::*;
#(
    parameter type entry_t = tile_pxl_t
) (
    input  wire         clk,
    input  wire         we,
    input  wire [9:0]   wr_addr,
    input  wire entry_t wr_data,
    input  wire [9:0]   rd_addr,
    output entry_t      rd_data
);

    entry_t mem [0:2*LINE_DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data is ready the cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- pixel_mixer.sv
// Pixel mixer
// Reads the three line buffers at the beam position, applies the layer
// windows, border and top blanking, and resolves tile against object
// priority into a 7-bit palette index two cycles after pxl_cen
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer
    import gfx_cfg_pkg::*, gfx_pix_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            pxl_cen,
    input  wire pos_t      hdump,
    input  wire pos_t      vdump,
    input  wire            line,
    input  wire            layout,
    input  wire            narrow_en,
    input  wire            flip,
    input  wire            scrwin_en,
    input  wire pal_bank_t pal_bank,
    input  wire tile_pxl_t chr_pxl,
    input  wire tile_pxl_t scr_pxl,
    input  wire obj_pxl_t  obj_pxl,
    output logic [9:0]     rd_addr,
    output pal_idx_t       pxl_out,
    output logic           pxl_valid
);

    pos_t       chr_start, chr_end, scr_start, scr_end;
    pos_t       hdump_q, vdump_q;
    logic       cen_q;
    logic       chr_area, scr_area, draw_scr;
    logic       chr_blank, obj_blank, tile_blank;
    logic       border_wide, border_narrow, blank_area;
    logic       tile_front;
    logic [3:0] tile_col;

    // Read bank is the one not being written
    assign rd_addr = {~line, hdump};

    always_comb begin
        if (!layout) begin
            chr_start = NARROW_START;
            chr_end   = NARROW_END;
            scr_start = NARROW_START;
            scr_end   = NARROW_END;
        end else if (flip) begin
            chr_start = WIDE_FLIP_SPLIT;
            chr_end   = WIDE_SCR_END;
            scr_start = '0;
            scr_end   = WIDE_FLIP_SPLIT;
        end else begin
            chr_start = '0;
            chr_end   = WIDE_CHR_END;
            scr_start = WIDE_CHR_END;
            scr_end   = WIDE_SCR_END;
        end
    end

    // Beam position delayed to match the buffer read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_q <= 1'b0;
        end else begin
            cen_q <= pxl_cen;
        end
    end

    always_ff @(posedge clk) begin
        hdump_q <= hdump;
        vdump_q <= vdump;
    end

    assign chr_area  = (hdump_q >= chr_start) && (hdump_q < chr_end);
    assign scr_area  = (hdump_q >= scr_start) && (hdump_q < scr_end);
    assign chr_blank = (chr_pxl[3:0] == 4'h0);
    assign obj_blank = (obj_pxl[3:0] == 4'h0);

    // Outside the shared area the window decides, inside it transparency does
    assign draw_scr   = (chr_area != scr_area) ? scr_area : chr_blank;
    assign tile_col   = draw_scr ? scr_pxl[3:0] : chr_pxl[3:0];
    assign tile_blank = (tile_col == 4'h0);

    assign border_wide   = (hdump_q < BORDER_WIDE_LO) || (hdump_q >= BORDER_WIDE_HI);
    assign border_narrow = narrow_en &&
                           ((hdump_q < BORDER_NARROW_LO) || (hdump_q >= BORDER_NARROW_HI));
    assign blank_area    = (vdump_q < VBLANK_TOP) ||
                           (!layout && (border_wide || border_narrow));

    // Scroll window flag lives in bit 8 of the scroll entry
    assign tile_front = obj_blank || (layout && chr_area) ||
                        (scrwin_en && scr_pxl[8] && !tile_blank);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_out   <= '0;
            pxl_valid <= 1'b0;
        end else begin
            pxl_valid <= cen_q;
            if (cen_q) begin
                if (blank_area) begin
                    pxl_out <= '0;
                end else begin
                    pxl_out <= {pal_bank, tile_front, tile_front ? tile_col : obj_pxl[3:0]};
                end
            end
        end
    end

    a_top_rows_blank: assert property (
        @(posedge clk) disable iff (rst)
        (pxl_valid && ($past(vdump, 2) < VBLANK_TOP)) |-> (pxl_out == '0)
    );

endmodule

`default_nettype wire

//--- gfx_mixer.sv
// Video back end top level
// Configuration registers, the pixel line writer, three ping-pong line
// buffers for the character, scroll and object layers, and the mixer
`timescale 1ns/1ps
`default_nettype none

module gfx_mixer
    import gfx_cfg_pkg::*, gfx_pix_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            pxl_cen,
    input  wire            line,
    input  wire            cfg_we,
    input  wire cfg_addr_t cfg_addr,
    input  wire cfg_data_t cfg_din,
    input  wire            wr_req,
    input  wire layer_t    wr_layer,
    input  wire pos_t      wr_addr,
    input  wire wr_data_t  wr_data,
    input  wire pos_t      hdump,
    input  wire pos_t      vdump,
    output logic           wr_ack,
    output logic           flip,
    output pal_idx_t       pxl_out,
    output logic           pxl_valid
);

    logic        layout, narrow_en, scrwin_en;
    pal_bank_t   pal_bank;
    logic        chr_we, scr_we, obj_we;
    logic [9:0]  buf_addr, rd_addr;
    wr_data_t    buf_data;
    tile_pxl_t   chr_pxl, scr_pxl;
    obj_pxl_t    obj_pxl;

    gfx_cfg_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_din   (cfg_din),
        .layout    (layout),
        .narrow_en (narrow_en),
        .flip      (flip),
        .scrwin_en (scrwin_en),
        .pal_bank  (pal_bank)
    );

    line_writer u_writer (
        .clk      (clk),
        .rst      (rst),
        .wr_req   (wr_req),
        .wr_layer (wr_layer),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .line     (line),
        .wr_ack   (wr_ack),
        .chr_we   (chr_we),
        .scr_we   (scr_we),
        .obj_we   (obj_we),
        .buf_addr (buf_addr),
        .buf_data (buf_data)
    );

    line_buffer #(.entry_t(tile_pxl_t)) u_chr_line (
        .clk     (clk),
        .we      (chr_we),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .rd_addr (rd_addr),
        .rd_data (chr_pxl)
    );

    line_buffer #(.entry_t(tile_pxl_t)) u_scr_line (
        .clk     (clk),
        .we      (scr_we),
        .wr_addr (buf_addr),
        .wr_data (buf_data),
        .rd_addr (rd_addr),
        .rd_data (scr_pxl)
    );

    // Objects carry no window flag, only the low byte is kept
    line_buffer #(.entry_t(obj_pxl_t)) u_obj_line (
        .clk     (clk),
        .we      (obj_we),
        .wr_addr (buf_addr),
        .wr_data (buf_data[7:0]),
        .rd_addr (rd_addr),
        .rd_data (obj_pxl)
    );

    pixel_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hdump     (hdump),
        .vdump     (vdump),
        .line      (line),
        .layout    (layout),
        .narrow_en (narrow_en),
        .flip      (flip),
        .scrwin_en (scrwin_en),
        .pal_bank  (pal_bank),
        .chr_pxl   (chr_pxl),
        .scr_pxl   (scr_pxl),
        .obj_pxl   (obj_pxl),
        .rd_addr   (rd_addr),
        .pxl_out   (pxl_out),
        .pxl_valid (pxl_valid)
    );

endmodule

`default_nettype wire

//--- tb_gfx_mixer.sv
// Testbench for the video back end
// Random pixel writes over the req/ack port, CPU register writes and line
// scans, checked against a reference model of the layer windows, blanking
// and tile/object priority
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_mixer
    import gfx_cfg_pkg::*, gfx_pix_pkg::*;
();

    localparam int    SCAN_LEN       = 304;
    localparam int    SCANS_PER_TEST = 3;
    localparam int    NUM_SCANS      = 4 * SCANS_PER_TEST;
    // Initial fill of both banks, measured in 600-cycle scan slots
    localparam int    FILL_SLOTS     = (2 * 3 * SCAN_LEN * 4 + 599) / 600;
    localparam longint WATCHDOG_NS   = longint'(NUM_SCANS + FILL_SLOTS + 2) * 600 * 20;

    logic      clk, rst, pxl_cen, line, cfg_we, wr_req, wr_ack, flip, pxl_valid;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_din;
    layer_t    wr_layer;
    pos_t      wr_addr, hdump, vdump;
    wr_data_t  wr_data;
    pal_idx_t  pxl_out;

    // Reference model state
    tile_pxl_t   chr_model [0:1023];
    tile_pxl_t   scr_model [0:1023];
    obj_pxl_t    obj_model [0:1023];
    logic        m_layout, m_narrow, m_flip, m_scrwin;
    pal_bank_t   m_pal;
    pal_idx_t    exp_q [$];
    int          due_q [$];
    pal_idx_t    exp_pxl;
    int          cyc = 0;
    logic        scan_done;
    logic [31:0] lfsr_state = 32'hf4ee825d;

    gfx_mixer dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pxl(input string name, input pal_idx_t got, input pal_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Transparent about half the time
    function automatic wr_data_t rand_pixel();
        wr_data_t v;
        v = wr_data_t'(rand_bits(9));
        if (rand_bits(1) != 0) v[3:0] = 4'h0;
        return v;
    endfunction

    function automatic pal_idx_t model_pixel(input pos_t h, input pos_t v, input logic bank);
        tile_pxl_t  c, s;
        obj_pxl_t   o;
        logic       in_chr, in_scr, blank, tile_on;
        logic [3:0] col;
        c = chr_model[{bank, h}];
        s = scr_model[{bank, h}];
        o = obj_model[{bank, h}];
        if (!m_layout) begin
            in_chr = (h >= 16) && (h < 264);
            in_scr = in_chr;
        end else if (!m_flip) begin
            in_chr = (h < 40);
            in_scr = (h >= 40) && (h < 296);
        end else begin
            in_chr = (h >= 240) && (h < 296);
            in_scr = (h < 240);
        end
        if (in_chr && !in_scr) col = c[3:0];
        else if (in_scr && !in_chr) col = s[3:0];
        else col = (c[3:0] == 4'h0) ? s[3:0] : c[3:0];
        blank = (v < 16) || (!m_layout && ((h < 16) || (h >= 272) ||
                (m_narrow && ((h < 24) || (h >= 264)))));
        tile_on = (o[3:0] == 4'h0) || (m_layout && in_chr) ||
                  (m_scrwin && s[8] && (col != 4'h0));
        if (blank) return '0;
        return {m_pal, tile_on, tile_on ? col : o[3:0]};
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic cfg_write(input cfg_addr_t a, input cfg_data_t d);
        cfg_we   = 1'b1;
        cfg_addr = a;
        cfg_din  = d;
        tick();
        cfg_we = 1'b0;
        case (a)
            REG_MODE: begin
                m_layout = d[4];
                m_narrow = d[6];
            end
            REG_PRIO: begin
                m_scrwin = d[3];
                m_pal    = d[5:4];
            end
            REG_CTRL: m_flip = d[3];
            default: begin
            end
        endcase
        check_bit("flip", flip, m_flip);
    endtask

    // Full four-phase handshake, ack edges checked cycle by cycle
    task automatic pixel_write(input layer_t l, input pos_t a, input wr_data_t d);
        wr_layer = l;
        wr_addr  = a;
        wr_data  = d;
        wr_req   = 1'b1;
        tick();
        check_bit("wr_ack", wr_ack, 1'b0);
        tick();
        check_bit("wr_ack", wr_ack, 1'b1);
        wr_req = 1'b0;
        tick();
        check_bit("wr_ack", wr_ack, 1'b1);
        tick();
        check_bit("wr_ack", wr_ack, 1'b0);
        case (l)
            LYR_CHR: chr_model[{line, a}] = d;
            LYR_SCR: scr_model[{line, a}] = d;
            default: obj_model[{line, a}] = d[7:0];
        endcase
    endtask

    task automatic write_random();
        layer_t l;
        pos_t   a;
        l = layer_t'(rand_bits(2));
        if (l == 2'd3) l = LYR_OBJ;
        a = pos_t'(rand_bits(9) % SCAN_LEN);
        pixel_write(l, a, rand_pixel());
    endtask

    task automatic fill_line();
        for (int h = 0; h < SCAN_LEN; h++) begin
            for (int l = 0; l < 3; l++) begin
                pixel_write(layer_t'(l), pos_t'(h), rand_pixel());
            end
        end
    endtask

    // Random config traffic, then the mode bits this scan needs
    task automatic configure(input logic wide, input logic flip_v, input logic scrwin_v);
        cfg_data_t d;
        repeat (3) cfg_write(cfg_addr_t'(rand_bits(3)), cfg_data_t'(rand_bits(8)));
        d = cfg_data_t'(rand_bits(8));
        d[4] = wide;
        cfg_write(REG_MODE, d);
        d = cfg_data_t'(rand_bits(8));
        d[3] = flip_v;
        cfg_write(REG_CTRL, d);
        d = cfg_data_t'(rand_bits(8));
        d[3] = scrwin_v;
        cfg_write(REG_PRIO, d);
    endtask

    task automatic scan_line(input logic cen_full);
        pos_t v;
        v = (rand_bits(2) == 0) ? pos_t'(rand_bits(4)) : pos_t'(rand_bits(9));
        vdump = v;
        for (int h = 0; h < SCAN_LEN; h++) begin
            if (!cen_full && (rand_bits(1) != 0)) begin
                pxl_cen = 1'b0;
                tick();
            end
            hdump   = pos_t'(h);
            pxl_cen = 1'b1;
            exp_q.push_back(model_pixel(hdump, v, ~line));
            due_q.push_back(cyc + 2);
            tick();
        end
        pxl_cen = 1'b0;
        // Wait until the monitor has retired every pixel of the scan
        while (due_q.size() != 0) begin
            tick();
        end
    endtask

    // Write bank is refilled while the read bank is on screen
    task automatic scan_with_writes(input logic cen_full);
        scan_done = 1'b0;
        fork
            begin
                scan_line(cen_full);
                scan_done = 1'b1;
            end
            begin
                while (!scan_done) write_random();
            end
        join
        line = ~line;
    endtask

    // Output monitor, pxl_valid due exactly two cycles after pxl_cen
    always @(posedge clk) begin
        #1;
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            check_bit("pxl_valid", pxl_valid, 1'b1);
            void'(due_q.pop_front());
            exp_pxl = exp_q.pop_front();
            check_pxl("pxl_out", pxl_out, exp_pxl);
        end else begin
            check_bit("pxl_valid", pxl_valid, 1'b0);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("simulation timed out before the tests finished");
    end

    initial begin : main
        rst      = 1'b1;
        pxl_cen  = 1'b0;
        line     = 1'b0;
        cfg_we   = 1'b0;
        cfg_addr = '0;
        cfg_din  = '0;
        wr_req   = 1'b0;
        wr_layer = '0;
        wr_addr  = '0;
        wr_data  = '0;
        hdump    = '0;
        vdump    = '0;
        {m_layout, m_narrow, m_flip, m_scrwin, m_pal} = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check_bit("wr_ack", wr_ack, 1'b0);
        check_bit("pxl_valid", pxl_valid, 1'b0);
        check_pxl("pxl_out", pxl_out, '0);
        check_bit("flip", flip, 1'b0);
        repeat (32) cfg_write(cfg_addr_t'(rand_bits(3)), cfg_data_t'(rand_bits(8)));
        fill_line();
        line = 1'b1;
        fill_line();
        // Narrow layout
        for (int i = 0; i < SCANS_PER_TEST; i++) begin
            configure(1'b0, 1'(rand_bits(1)), 1'(rand_bits(1)));
            scan_with_writes(1'b0);
        end
        // Wide layout, then wide and flipped
        for (int i = 0; i < SCANS_PER_TEST; i++) begin
            configure(1'b1, 1'b0, 1'(rand_bits(1)));
            scan_with_writes(1'b0);
        end
        for (int i = 0; i < SCANS_PER_TEST; i++) begin
            configure(1'b1, 1'b1, 1'(rand_bits(1)));
            scan_with_writes(1'b0);
        end
        // Priority with back-to-back pixels
        for (int i = 0; i < SCANS_PER_TEST; i++) begin
            configure(1'(rand_bits(1)), 1'(rand_bits(1)), 1'(i % 2));
            scan_with_writes(1'b1);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
gfx_cfg_pkg.sv
gfx_pix_pkg.sv
gfx_cfg_regs.sv
line_writer.sv
line_buffer.sv
pixel_mixer.sv
gfx_mixer.sv
tb_gfx_mixer.sv

//--- Bender.yml
package:
  name: gfx_mixer

sources:
  - files:
      - gfx_cfg_pkg.sv
      - gfx_pix_pkg.sv
      - gfx_cfg_regs.sv
      - line_writer.sv
      - line_buffer.sv
      - pixel_mixer.sv
      - gfx_mixer.sv
  - target: simulation
    files:
      - tb_gfx_mixer.sv
